// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  //////////////////////////////
  // Bus geometry
  //////////////////////////////

  localparam int DATA_W  = 32;          // Data bus width
  localparam int BYTES_W = DATA_W / 8;  // Byte lanes per word

  typedef logic [DATA_W-1:0]  data_t;    // One bus word
  typedef logic [31:0]        addr_t;    // Byte address
  typedef logic [BYTES_W-1:0] be_t;      // One enable per lane
  typedef logic [1:0]         offset_t;  // Byte within word

  //////////////////////////////
  // Access and FSM encodings
  //////////////////////////////

  // Access size, same codes as the core's data_type field
  typedef enum logic [1:0] {
    TYPE_WORD = 2'b00,
    TYPE_HALF = 2'b01,
    TYPE_BYTE = 2'b10
  } data_type_e;

  typedef enum logic [1:0] {
    REQ_IDLE        = 2'b00,  // Ready for a core strobe
    REQ_WAIT_GNT    = 2'b01,  // First phase on the bus
    REQ_WAIT_RVALID = 2'b10,  // Granted, response pending
    REQ_SECOND      = 2'b11   // Second phase of a split access
  } req_state_e;

endpackage

`default_nettype wire

// File: hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

  typedef logic [11:0] csr_addr_t;  // CSR address space
  typedef logic [31:0] cnt_t;       // Counter and CSR data word

  // Op codes as driven by the core's CSR port
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Register map
  localparam csr_addr_t CSR_PCER         = 12'h7E0;  // Counter enables
  localparam csr_addr_t CSR_CNT_LOAD     = 12'h780;
  localparam csr_addr_t CSR_CNT_STORE    = 12'h781;
  localparam csr_addr_t CSR_CNT_MISALIGN = 12'h782;

  // Enable bit per event, also the counter index
  localparam int PCER_LOAD_BIT     = 0;
  localparam int PCER_STORE_BIT    = 1;
  localparam int PCER_MISALIGN_BIT = 2;
  localparam int N_CNT             = 3;

endpackage

`default_nettype wire

// File: hdl/lsu_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_req_ctrl (
  input  logic                clk_i,
  input  logic                reset_i,

  // Core side
  input  logic                req_i,
  input  logic                we_i,
  input  lsu_pkg::data_type_e type_i,
  input  logic                sign_ext_i,
  input  lsu_pkg::addr_t      addr_i,
  input  lsu_pkg::data_t      wdata_i,
  output logic                ready_o,
  output logic                rvalid_o,
  output logic                busy_o,

  // Data bus control
  output logic                data_req_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  output logic                data_we_o,
  output lsu_pkg::addr_t      data_addr_o,

  // To the aligner
  output lsu_pkg::offset_t    offset_o,
  output lsu_pkg::data_type_e type_o,
  output logic                sign_ext_o,
  output lsu_pkg::data_t      wdata_o,
  output logic                phase_o,
  output logic                capture_o,

  // To the counters
  output logic                misalign_o
);

  lsu_pkg::req_state_e state_q, state_d;

  logic                accept;         // Strobe taken this cycle
  logic                misaligned_in;  // Incoming access crosses a word
  logic                misalign_q;
  logic                phase_q;        // 0 first word, 1 next word
  logic                rvalid_q;
  logic                last_rvalid;

  // Latched request
  lsu_pkg::addr_t      addr_q;
  lsu_pkg::data_t      wdata_q;
  lsu_pkg::data_type_e type_q;
  logic                sign_ext_q;
  logic                we_q;

  lsu_pkg::addr_t      word_addr;
  lsu_pkg::addr_t      next_word_addr;

  assign ready_o = (state_q == lsu_pkg::REQ_IDLE);
  assign accept  = req_i & ready_o;

  // Word at any nonzero offset, half only when it spills past lane 3
  always_comb begin
    case (type_i)
      lsu_pkg::TYPE_WORD: misaligned_in = (addr_i[1:0] != 2'b00);
      lsu_pkg::TYPE_HALF: misaligned_in = (addr_i[1:0] == 2'b11);
      default:            misaligned_in = 1'b0;
    endcase
  end

  assign misalign_o = accept & misaligned_in;

  //////////////////////////////
  // Request FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::REQ_IDLE: begin
        if (accept) state_d = lsu_pkg::REQ_WAIT_GNT;
      end
      lsu_pkg::REQ_WAIT_GNT,
      lsu_pkg::REQ_SECOND: begin
        if (data_gnt_i) state_d = lsu_pkg::REQ_WAIT_RVALID;  // Hold request until granted
      end
      lsu_pkg::REQ_WAIT_RVALID: begin
        if (data_rvalid_i) begin
          // Split access goes back on the bus for the upper word
          state_d = (misalign_q & ~phase_q) ? lsu_pkg::REQ_SECOND : lsu_pkg::REQ_IDLE;
        end
      end
      default: state_d = lsu_pkg::REQ_IDLE;
    endcase
  end

  // Response that closes the request
  assign last_rvalid = (state_q == lsu_pkg::REQ_WAIT_RVALID) & data_rvalid_i &
                       ~(misalign_q & ~phase_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= lsu_pkg::REQ_IDLE;
      phase_q    <= 1'b0;
      misalign_q <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= last_rvalid;  // Result one cycle after last response
      if (accept) begin
        phase_q    <= 1'b0;
        misalign_q <= misaligned_in;
      end else if (state_d == lsu_pkg::REQ_SECOND) begin
        phase_q <= 1'b1;
      end
    end
  end

  // Payload, loaded with the strobe
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q     <= addr_i;
      wdata_q    <= wdata_i;
      type_q     <= type_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= we_i;
    end
  end

  //////////////////////////////
  // Bus and aligner outputs
  //////////////////////////////

  assign word_addr      = {addr_q[31:2], 2'b00};
  assign next_word_addr = word_addr + 32'd4;

  assign data_req_o  = (state_q == lsu_pkg::REQ_WAIT_GNT) | (state_q == lsu_pkg::REQ_SECOND);
  assign data_addr_o = phase_q ? next_word_addr : word_addr;
  assign data_we_o   = we_q;

  assign offset_o   = addr_q[1:0];
  assign type_o     = type_q;
  assign sign_ext_o = sign_ext_q;
  assign wdata_o    = wdata_q;
  assign phase_o    = phase_q;
  assign capture_o  = (state_q == lsu_pkg::REQ_WAIT_RVALID) & data_rvalid_i;  // Every phase

  assign rvalid_o = rvalid_q;
  assign busy_o   = ~ready_o | rvalid_q;  // Still high in the result cycle

endmodule

`default_nettype wire

// File: hdl/lsu_data_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_data_align (
  input  logic                clk_i,
  input  logic                reset_i,

  // Latched request
  input  lsu_pkg::offset_t    offset_i,
  input  lsu_pkg::data_type_e type_i,
  input  logic                sign_ext_i,
  input  logic                phase_i,
  input  logic                capture_i,
  input  lsu_pkg::data_t      wdata_i,

  // Bus data
  input  lsu_pkg::data_t      data_rdata_i,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::data_t      data_wdata_o,

  // Load result
  output lsu_pkg::data_t      rdata_o
);

  lsu_pkg::be_t                      size_mask;  // Access bytes at lane 0
  logic [2*lsu_pkg::BYTES_W-1:0]     be_wide;    // Enables across two words
  logic [4:0]                        shift;      // Offset in bits
  logic [2*lsu_pkg::DATA_W-1:0]      wr_dbl;
  logic [2*lsu_pkg::DATA_W-1:0]      rd_dbl;
  lsu_pkg::data_t                    rd_q;       // Merged read word
  lsu_pkg::data_t                    rd_rot;

  assign shift = {offset_i, 3'b000};

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  always_comb begin
    case (type_i)
      lsu_pkg::TYPE_WORD: size_mask = 4'b1111;
      lsu_pkg::TYPE_HALF: size_mask = 4'b0011;
      lsu_pkg::TYPE_BYTE: size_mask = 4'b0001;
      default:            size_mask = 4'b0000;
    endcase
  end

  // Lanes past the top of the first word spill into the next one
  assign be_wide   = {{lsu_pkg::BYTES_W{1'b0}}, size_mask} << offset_i;
  assign data_be_o = phase_i ? be_wide[2*lsu_pkg::BYTES_W-1:lsu_pkg::BYTES_W]
                             : be_wide[lsu_pkg::BYTES_W-1:0];

  // Rotate left, same word for both phases
  assign wr_dbl       = {wdata_i, wdata_i} << shift;
  assign data_wdata_o = wr_dbl[2*lsu_pkg::DATA_W-1:lsu_pkg::DATA_W];

  //////////////////////////////
  // Read capture and merge
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_q <= '0;
    end else if (capture_i) begin
      for (int i = 0; i < lsu_pkg::BYTES_W; i++) begin
        // Second phase only overwrites its own low lanes
        if (!phase_i || data_be_o[i]) rd_q[8*i +: 8] <= data_rdata_i[8*i +: 8];
      end
    end
  end

  assign rd_dbl = {rd_q, rd_q} >> shift;  // Rotate right by the offset
  assign rd_rot = rd_dbl[lsu_pkg::DATA_W-1:0];

  // Extension from access size
  always_comb begin
    case (type_i)
      lsu_pkg::TYPE_HALF: rdata_o = {{16{sign_ext_i & rd_rot[15]}}, rd_rot[15:0]};
      lsu_pkg::TYPE_BYTE: rdata_o = {{24{sign_ext_i & rd_rot[7]}}, rd_rot[7:0]};
      default:            rdata_o = rd_rot;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/lsu_perf_csr.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_perf_csr (
  input  logic               clk_i,
  input  logic               reset_i,

  // Observed bus and LSU events
  input  logic               data_req_i,
  input  logic               data_gnt_i,
  input  logic               data_we_i,
  input  logic               misalign_i,

  // CSR access
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  csr_pkg::cnt_t      csr_wdata_i,
  output csr_pkg::cnt_t      csr_rdata_o
);

  logic [csr_pkg::N_CNT-1:0] pcer_q;    // Per counter enable
  logic [csr_pkg::N_CNT-1:0] event_in;
  csr_pkg::cnt_t             cnt_q    [csr_pkg::N_CNT];
  csr_pkg::csr_addr_t        cnt_addr [csr_pkg::N_CNT];
  csr_pkg::cnt_t             csr_new;   // Value after the op
  logic                      csr_we;

  // Events indexed by their enable bit
  assign event_in[csr_pkg::PCER_LOAD_BIT]     = data_req_i & data_gnt_i & ~data_we_i;
  assign event_in[csr_pkg::PCER_STORE_BIT]    = data_req_i & data_gnt_i & data_we_i;
  assign event_in[csr_pkg::PCER_MISALIGN_BIT] = misalign_i;

  assign cnt_addr[csr_pkg::PCER_LOAD_BIT]     = csr_pkg::CSR_CNT_LOAD;
  assign cnt_addr[csr_pkg::PCER_STORE_BIT]    = csr_pkg::CSR_CNT_STORE;
  assign cnt_addr[csr_pkg::PCER_MISALIGN_BIT] = csr_pkg::CSR_CNT_MISALIGN;

  //////////////////////////////
  // Read decode and op
  //////////////////////////////

  always_comb begin
    csr_rdata_o = '0;  // Unmapped addresses read zero
    if (csr_addr_i == csr_pkg::CSR_PCER) csr_rdata_o = csr_pkg::cnt_t'(pcer_q);
    for (int i = 0; i < csr_pkg::N_CNT; i++) begin
      if (csr_addr_i == cnt_addr[i]) csr_rdata_o = cnt_q[i];
    end
  end

  // Set and clear work on the current register value
  always_comb begin
    case (csr_op_i)
      csr_pkg::CSR_OP_WRITE: csr_new = csr_wdata_i;
      csr_pkg::CSR_OP_SET:   csr_new = csr_rdata_o | csr_wdata_i;
      csr_pkg::CSR_OP_CLEAR: csr_new = csr_rdata_o & ~csr_wdata_i;
      default:               csr_new = csr_rdata_o;
    endcase
  end

  assign csr_we = csr_access_i & (csr_op_i != csr_pkg::CSR_OP_NONE);

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pcer_q <= '1;  // All events counted
    end else if (csr_we && csr_addr_i == csr_pkg::CSR_PCER) begin
      pcer_q <= csr_new[csr_pkg::N_CNT-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < csr_pkg::N_CNT; i++) begin
      if (reset_i) begin
        cnt_q[i] <= '0;
      end else if (csr_we && csr_addr_i == cnt_addr[i]) begin
        cnt_q[i] <= csr_new;  // Software access beats the event
      end else if (event_in[i] && pcer_q[i]) begin
        cnt_q[i] <= cnt_q[i] + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                clk_i,
  input  logic                reset_i,

  // Core request side
  input  logic                req_i,
  input  logic                we_i,
  input  lsu_pkg::data_type_e type_i,
  input  logic                sign_ext_i,
  input  lsu_pkg::addr_t      addr_i,
  input  lsu_pkg::data_t      wdata_i,
  output logic                ready_o,
  output logic                rvalid_o,
  output lsu_pkg::data_t      rdata_o,
  output logic                busy_o,

  // Data memory bus
  output logic                data_req_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::addr_t      data_addr_o,
  output lsu_pkg::data_t      data_wdata_o,
  input  lsu_pkg::data_t      data_rdata_i,

  // CSR port
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  csr_pkg::cnt_t       csr_wdata_i,
  output csr_pkg::cnt_t       csr_rdata_o
);

  // Request control to aligner
  lsu_pkg::offset_t    offset;
  lsu_pkg::data_type_e type_q;
  logic                sign_ext;
  lsu_pkg::data_t      wdata_q;
  logic                phase;     // High during second bus phase
  logic                capture;   // Read word arrives this cycle
  logic                misalign;  // One pulse per split request

  //////////////////////////////
  // Request sequencing
  //////////////////////////////

  lsu_req_ctrl req_ctrl_i (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .req_i         ( req_i         ),
    .we_i          ( we_i          ),
    .type_i        ( type_i        ),
    .sign_ext_i    ( sign_ext_i    ),
    .addr_i        ( addr_i        ),
    .wdata_i       ( wdata_i       ),
    .ready_o       ( ready_o       ),
    .rvalid_o      ( rvalid_o      ),
    .busy_o        ( busy_o        ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .offset_o      ( offset        ),
    .type_o        ( type_q        ),
    .sign_ext_o    ( sign_ext      ),
    .wdata_o       ( wdata_q       ),
    .phase_o       ( phase         ),
    .capture_o     ( capture       ),
    .misalign_o    ( misalign      )
  );

  //////////////////////////////
  // Byte lanes
  //////////////////////////////

  lsu_data_align data_align_i (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .offset_i     ( offset       ),
    .type_i       ( type_q       ),
    .sign_ext_i   ( sign_ext     ),
    .phase_i      ( phase        ),
    .capture_i    ( capture      ),
    .wdata_i      ( wdata_q      ),
    .data_rdata_i ( data_rdata_i ),
    .data_be_o    ( data_be_o    ),
    .data_wdata_o ( data_wdata_o ),
    .rdata_o      ( rdata_o      )
  );

  //////////////////////////////
  // Performance counters
  //////////////////////////////

  lsu_perf_csr perf_csr_i (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .data_req_i   ( data_req_o   ),  // Granted loads and stores seen on the bus
    .data_gnt_i   ( data_gnt_i   ),
    .data_we_i    ( data_we_o    ),
    .misalign_i   ( misalign     ),
    .csr_access_i ( csr_access_i ),
    .csr_addr_i   ( csr_addr_i   ),
    .csr_op_i     ( csr_op_i     ),
    .csr_wdata_i  ( csr_wdata_i  ),
    .csr_rdata_o  ( csr_rdata_o  )
  );

endmodule

`default_nettype wire

// File: testbench/lsu_props.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_props (
  input logic        clk_i,
  input logic        reset_i,
  input logic        req_i,
  input logic        ready_o,
  input logic        data_req_o,
  input logic        data_gnt_i,
  input logic        data_rvalid_i,
  input logic [31:0] data_addr_o
);

  logic outstanding_q;       // Granted with no response yet
  int   assert_fails = 0;    // Failed assertion count

  always_ff @(posedge clk_i) begin
    if (reset_i) outstanding_q <= 1'b0;
    else if (data_req_o && data_gnt_i) outstanding_q <= 1'b1;
    else if (data_rvalid_i) outstanding_q <= 1'b0;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o))
    else begin
      assert_fails++;
      $error("Bus request dropped or moved before grant");
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    data_rvalid_i |-> outstanding_q)
    else begin
      assert_fails++;
      $error("Response without an outstanding grant");
    end

  // New bus request only after an accepted strobe or a first-phase response
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(data_req_o) |-> $past(req_i && ready_o) || $past(data_rvalid_i))
    else begin
      assert_fails++;
      $error("Bus request started without an accepted strobe");
    end

endmodule

bind lsu_top lsu_props props_i (
  .clk_i         ( clk_i         ),
  .reset_i       ( reset_i       ),
  .req_i         ( req_i         ),
  .ready_o       ( ready_o       ),
  .data_req_o    ( data_req_o    ),
  .data_gnt_i    ( data_gnt_i    ),
  .data_rvalid_i ( data_rvalid_i ),
  .data_addr_o   ( data_addr_o   )
);

`default_nettype wire

// File: testbench/lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [1:0]  type_i,
  input  logic [31:0] addr_i,
  input  logic        ready_i,
  input  logic        rvalid_i,
  input  logic [31:0] rdata_i,
  input  logic        busy_i,
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic [31:0] data_addr_i,
  input  logic        csr_access_i,
  input  logic [31:0] csr_rdata_i,
  input  logic [31:0] exp_rdata_i,
  input  logic [31:0] exp_csr_i,
  input  int          test_num_i
);

  int          value_errs = 0;
  int          other_errs = 0;
  logic        was_reset  = 1'b0;
  logic        pending    = 1'b0;  // Access accepted with no result yet
  logic        split;              // Access crosses a word
  logic        load;
  logic [31:0] exp_q;
  logic [31:0] word_q;             // Word address of first phase
  int          test_q;
  int          n_gnt;
  int          wait_cnt;

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    value_errs++;
  endtask

  task automatic report_counts(input int assert_errs);
    $display("Checker: %0d value errors, %0d other errors, %0d assertion failures",
             value_errs, other_errs, assert_errs);
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      was_reset = 1'b1;
      pending   = 1'b0;
    end else begin
      // First cycle out of reset
      if (was_reset) begin
        if (!ready_i || rvalid_i || busy_i || data_req_i) begin
          $display("Outputs are not in their idle state after reset");
          other_errs++;
        end
        was_reset = 1'b0;
      end
      // Busy spans the accepted request up to its result cycle
      if (busy_i !== pending) begin
        $display("busy_o is %b while vector %0d is %0s", busy_i, test_q,
                 pending ? "in flight" : "finished");
        other_errs++;
      end
      if (data_req_i && data_gnt_i) begin
        if (n_gnt == 0 && data_addr_i != word_q)
          value_error($sformatf("vector %0d first address", test_q), word_q, data_addr_i);
        if (n_gnt == 1 && data_addr_i != word_q + 32'd4)
          value_error($sformatf("vector %0d second address", test_q), word_q + 4, data_addr_i);
        n_gnt++;
      end
      if (rvalid_i) begin
        if (!pending) begin
          $display("A result pulse came without an accepted request");
          other_errs++;
        end else begin
          if (n_gnt != (split ? 2 : 1)) begin
            $display("Vector %0d saw %0d bus transactions instead of %0d",
                     test_q, n_gnt, split ? 2 : 1);
            other_errs++;
          end
          if (load && rdata_i !== exp_q)
            value_error($sformatf("vector %0d load data", test_q), exp_q, rdata_i);
        end
        pending = 1'b0;
      end
      if (pending) begin
        wait_cnt++;
        if (wait_cnt == 200) begin
          $display("Vector %0d never produced its result pulse", test_q);
          other_errs++;
        end
      end
      if (req_i && ready_i) begin
        pending  = 1'b1;
        load     = !we_i;
        exp_q    = exp_rdata_i;
        test_q   = test_num_i;
        word_q   = {addr_i[31:2], 2'b00};
        split    = (type_i == 2'b00 && addr_i[1:0] != 2'b00) ||
                   (type_i == 2'b01 && addr_i[1:0] == 2'b11);
        n_gnt    = 0;
        wait_cnt = 0;
      end
      if (csr_access_i && csr_rdata_i !== exp_csr_i)  // Value before the op lands
        value_error($sformatf("vector %0d CSR read", test_num_i), exp_csr_i, csr_rdata_i);
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int MAX_VEC = 64;

  logic                clk_i;
  logic                reset_i;
  logic                req_i;
  logic                we_i;
  lsu_pkg::data_type_e type_i;
  logic                sign_ext_i;
  lsu_pkg::addr_t      addr_i;
  lsu_pkg::data_t      wdata_i;
  logic                ready_o;
  logic                rvalid_o;
  lsu_pkg::data_t      rdata_o;
  logic                busy_o;
  logic                data_req_o;
  logic                data_gnt_i;
  logic                data_rvalid_i;
  logic                data_we_o;
  lsu_pkg::be_t        data_be_o;
  lsu_pkg::addr_t      data_addr_o;
  lsu_pkg::data_t      data_wdata_o;
  lsu_pkg::data_t      data_rdata_i;
  logic                csr_access_i;
  csr_pkg::csr_addr_t  csr_addr_i;
  csr_pkg::csr_op_e    csr_op_i;
  csr_pkg::cnt_t       csr_wdata_i;
  csr_pkg::cnt_t       csr_rdata_o;

  logic [31:0] exp_rdata;   // Expected load result of the current access
  logic [31:0] exp_csr;     // Expected CSR read value
  int          test_num;

  // Vector table with columns set by the line kind
  byte         v_kind [MAX_VEC];
  logic [31:0] v_a [MAX_VEC];
  logic [31:0] v_b [MAX_VEC];
  logic [31:0] v_c [MAX_VEC];
  logic [31:0] v_d [MAX_VEC];
  logic [31:0] v_e [MAX_VEC];
  logic [31:0] v_f [MAX_VEC];
  int          n_vec;

  logic [31:0] mem [256];   // Word memory indexed by byte address bits 9:2
  logic [31:0] rng_state;

  lsu_top UUT (.*);

  lsu_checker chk_i (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .type_i       ( type_i       ),
    .addr_i       ( addr_i       ),
    .ready_i      ( ready_o      ),
    .rvalid_i     ( rvalid_o     ),
    .rdata_i      ( rdata_o      ),
    .busy_i       ( busy_o       ),
    .data_req_i   ( data_req_o   ),
    .data_gnt_i   ( data_gnt_i   ),
    .data_addr_i  ( data_addr_o  ),
    .csr_access_i ( csr_access_i ),
    .csr_rdata_i  ( csr_rdata_o  ),
    .exp_rdata_i  ( exp_rdata    ),
    .exp_csr_i    ( exp_csr      ),
    .test_num_i   ( test_num     )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int next_rand(input int range);
    rng_state = xorshift32(rng_state);
    return int'(rng_state % range);
  endfunction

  //////////////////////////////
  // Clock and vector file
  //////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    begin
      n_vec = 0;
      fd = $fopen("testbench/lsu_vectors.txt", "r");
      if (fd == 0) begin
        $display("Cannot open the vector file");
        return;
      end
      while (!$feof(fd) && n_vec < MAX_VEC) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
        v_kind[n_vec] = line.getc(0);
        if (v_kind[n_vec] == "A") begin
          cnt = $sscanf(line, "A %h %h %h %h %h %h", v_a[n_vec], v_b[n_vec], v_c[n_vec],
                        v_d[n_vec], v_e[n_vec], v_f[n_vec]);
          if (cnt == 6) n_vec++;
        end else if (v_kind[n_vec] == "C") begin
          cnt = $sscanf(line, "C %h %h %h %h", v_a[n_vec], v_b[n_vec], v_c[n_vec], v_d[n_vec]);
          if (cnt == 4) n_vec++;
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////
  // Memory model
  //////////////////////////////

  initial begin
    logic [7:0] idx;
    int         dly;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    rng_state     = 32'd23;
    for (int i = 0; i < 256; i++) mem[i] = '0;
    forever begin
      @(posedge clk_i);
      #1;
      data_gnt_i    = 1'b0;
      data_rvalid_i = 1'b0;
      if (data_req_o && !reset_i) begin
        dly = next_rand(4);  // Grant stall 0 to 3
        repeat (dly) begin
          @(posedge clk_i);
          #1;
        end
        data_gnt_i = 1'b1;
        idx = data_addr_o[9:2];
        if (data_we_o) begin
          for (int b = 0; b < 4; b++)
            if (data_be_o[b]) mem[idx][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
        @(posedge clk_i);
        #1;
        data_gnt_i = 1'b0;
        dly = 1 + next_rand(3);  // Response 1 to 3 cycles after grant
        repeat (dly - 1) begin
          @(posedge clk_i);
          #1;
        end
        data_rvalid_i = 1'b1;
        data_rdata_i  = mem[idx];
      end
    end
  end

  //////////////////////////////
  // Driver
  //////////////////////////////

  task automatic run_access(input int i);
    begin
      while (!ready_o) begin
        @(posedge clk_i);
        #1;
      end
      test_num   = i + 1;
      exp_rdata  = v_f[i];
      req_i      = 1'b1;
      we_i       = v_a[i][0];
      type_i     = lsu_pkg::data_type_e'(v_b[i][1:0]);
      sign_ext_i = v_c[i][0];
      addr_i     = v_d[i];
      wdata_i    = v_e[i];
      @(posedge clk_i);
      #1;
      req_i = 1'b0;
      while (!rvalid_o) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  task automatic run_csr(input int i);
    begin
      test_num     = i + 1;
      exp_csr      = v_d[i];
      csr_access_i = 1'b1;
      csr_op_i     = csr_pkg::csr_op_e'(v_a[i][1:0]);
      csr_addr_i   = v_b[i][11:0];
      csr_wdata_i  = v_c[i];
      @(posedge clk_i);
      #1;
      csr_access_i = 1'b0;
      csr_op_i     = csr_pkg::CSR_OP_NONE;
    end
  endtask

  initial begin
    reset_i      = 1'b1;
    req_i        = 1'b0;
    we_i         = 1'b0;
    type_i       = lsu_pkg::TYPE_WORD;
    sign_ext_i   = 1'b0;
    addr_i       = '0;
    wdata_i      = '0;
    csr_access_i = 1'b0;
    csr_addr_i   = '0;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
    csr_wdata_i  = '0;
    exp_rdata    = '0;
    exp_csr      = '0;
    test_num     = 0;
    load_vectors();
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < n_vec; i++) begin
      if (v_kind[i] == "A") run_access(i);
      else run_csr(i);
    end
    repeat (5) @(posedge clk_i);
    #1;
    chk_i.report_counts(UUT.props_i.assert_fails);
    if (n_vec > 0 &&
        chk_i.value_errs + chk_i.other_errs + UUT.props_i.assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog budget of 20 cycles per vector plus setup
  initial begin
    wait (n_vec > 0);
    repeat (n_vec * 20 + 100) @(posedge clk_i);
    $display("Timeout, the vectors did not finish in time");
    chk_i.report_counts(UUT.props_i.assert_fails);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/lsu_vectors.txt
# Access: A we type(0 word,1 half,2 byte) sext addr wdata expected_load (hex)
# CSR:    C op(0 none,1 write,2 set,3 clear) addr wdata expected_read_before_op (hex)
A 1 0 0 00000010 11223344 00000000
A 0 0 0 00000010 00000000 11223344
A 1 2 0 00000011 000000AA 00000000
A 1 1 0 00000016 0000BEEF 00000000
A 0 0 0 00000010 00000000 1122AA44
A 0 2 1 00000011 00000000 FFFFFFAA
A 0 2 0 00000011 00000000 000000AA
A 0 1 1 00000016 00000000 FFFFBEEF
A 0 1 0 00000016 00000000 0000BEEF
A 0 2 1 00000012 00000000 00000022
A 1 0 0 00000021 A1B2C3D4 00000000
A 0 0 0 00000021 00000000 A1B2C3D4
A 1 1 0 00000027 00005566 00000000
A 0 1 0 00000027 00000000 00005566
A 0 0 0 00000023 00000000 0000A1B2
A 0 1 1 00000023 00000000 FFFFA1B2
C 0 780 00000000 0000000F
C 0 781 00000000 00000007
C 0 782 00000000 00000006
C 3 780 FFFFFFFF 0000000F
C 0 780 00000000 00000000
C 3 7E0 00000002 00000007
A 1 0 0 00000030 12345678 00000000
A 0 0 0 00000030 00000000 12345678
C 0 781 00000000 00000007
C 0 780 00000000 00000001
C 0 7E0 00000000 00000005
C 0 123 00000000 00000000
C 1 781 00000000 00000007
C 0 781 00000000 00000000

// File: tb.f
hdl/lsu_pkg.sv
hdl/csr_pkg.sv
hdl/lsu_req_ctrl.sv
hdl/lsu_data_align.sv
hdl/lsu_perf_csr.sv
hdl/lsu_top.sv
testbench/lsu_props.sv
testbench/lsu_checker.sv
testbench/tb_top.sv

// File: Bender.yml
package:
  name: lsu_perf

sources:
  - hdl/lsu_pkg.sv
  - hdl/csr_pkg.sv
  - hdl/lsu_req_ctrl.sv
  - hdl/lsu_data_align.sv
  - hdl/lsu_perf_csr.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - testbench/lsu_props.sv
      - testbench/lsu_checker.sv
      - testbench/tb_top.sv
